// File: project.f
src/dma_cfg_pkg.sv
src/dma_types_pkg.sv
src/dma_req_sync.sv
src/dma_req_qualify.sv
src/dma_rr_arb.sv
src/dma_pri_sel.sv
src/dma_hs_ctrl.sv
src/dma_chsel.sv
tests/tb_dma_chsel.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f project.f \
  --top-module tb_dma_chsel -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_dma_chsel > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: src/dma_cfg_pkg.sv
`default_nettype none

package dma_cfg_pkg;

  // number of DMA channels served by the selector.
  localparam int NUM_CH = 4;

  // width of a channel number.
  localparam int CH_W = $clog2(NUM_CH);

  // number of fixed priority levels; one round-robin arbiter per level.
  localparam int PRI_LEVELS = 4;

  // width of a priority value.
  localparam int PRI_W = $clog2(PRI_LEVELS);

endpackage

`default_nettype wire

// File: src/dma_chsel.sv
`default_nettype none
`timescale 1ns/1ps

module dma_chsel (
  input  logic                                                HCLK,
  input  logic                                                HRSTn,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                      dma_req,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                      sync,
  input  logic                                                glb_en,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                      ch_en,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                      ch_abt,
  input  dma_types_pkg::xfer_mode_e [dma_cfg_pkg::NUM_CH-1:0] ch_mode,
  input  dma_types_pkg::pri_e [dma_cfg_pkg::NUM_CH-1:0]       ch_pri,
  input  logic                                                de_err_notify,
  input  logic                                                de_ack,
  input  logic                                                de_stup,
  input  logic                                                de_st_idle,
  input  logic                                                de_abt_on_idle,
  input  logic                                                tsz_eq0,
  output logic [dma_cfg_pkg::NUM_CH-1:0]                      dma_ack,
  output logic [dma_cfg_pkg::NUM_CH-1:0]                      dma_tc,
  output logic [dma_cfg_pkg::CH_W-1:0]                        arb_ch_sel,
  output logic                                                arb_req
);

  import dma_cfg_pkg::*;

  logic [NUM_CH-1:0] dma_reqs;
  logic [NUM_CH-1:0] vld_req;
  logic [NUM_CH-1:0] abnormal;
  logic [NUM_CH-1:0] ch_taken;  // engine is acking the selected channel.

  dma_req_sync u_req_sync (
    .HCLK     (HCLK),
    .HRSTn    (HRSTn),
    .dma_req  (dma_req),
    .sync     (sync),
    .dma_reqs (dma_reqs)
  );

  dma_req_qualify u_req_qualify (
    .glb_en        (glb_en),
    .ch_en         (ch_en),
    .ch_mode       (ch_mode),
    .ch_abt        (ch_abt),
    .de_err_notify (de_err_notify),
    .dma_reqs      (dma_reqs),
    .dma_ack       (dma_ack),
    .ch_taken      (ch_taken),
    .vld_req       (vld_req),
    .abnormal      (abnormal)
  );

  dma_pri_sel u_pri_sel (
    .HCLK           (HCLK),
    .HRSTn          (HRSTn),
    .vld_req        (vld_req),
    .ch_pri         (ch_pri),
    .de_stup        (de_stup),
    .de_st_idle     (de_st_idle),
    .de_abt_on_idle (de_abt_on_idle),
    .arb_ch_sel     (arb_ch_sel),
    .arb_req        (arb_req)
  );

  dma_hs_ctrl u_hs_ctrl (
    .HCLK       (HCLK),
    .HRSTn      (HRSTn),
    .arb_ch_sel (arb_ch_sel),
    .ch_mode    (ch_mode),
    .abnormal   (abnormal),
    .dma_reqs   (dma_reqs),
    .de_ack     (de_ack),
    .tsz_eq0    (tsz_eq0),
    .dma_ack    (dma_ack),
    .dma_tc     (dma_tc),
    .ch_taken   (ch_taken)
  );

endmodule

`default_nettype wire

// File: src/dma_hs_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module dma_hs_ctrl (
  input  logic                                                HCLK,
  input  logic                                                HRSTn,
  input  logic [dma_cfg_pkg::CH_W-1:0]                        arb_ch_sel,
  input  dma_types_pkg::xfer_mode_e [dma_cfg_pkg::NUM_CH-1:0] ch_mode,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                      abnormal,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                      dma_reqs,
  input  logic                                                de_ack,
  input  logic                                                tsz_eq0,
  output logic [dma_cfg_pkg::NUM_CH-1:0]                      dma_ack,
  output logic [dma_cfg_pkg::NUM_CH-1:0]                      dma_tc,
  output logic [dma_cfg_pkg::NUM_CH-1:0]                      ch_taken
);

  import dma_cfg_pkg::*;
  import dma_types_pkg::*;

  logic [NUM_CH-1:0] hs_ok;
  logic [NUM_CH-1:0] ack_nx;
  logic [NUM_CH-1:0] tc_nx;

  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      ch_taken[i] = de_ack & (arb_ch_sel == CH_W'(i));
      hs_ok[i]    = ch_taken[i] & (ch_mode[i] == MODE_HW) & ~abnormal[i];
      // set on the data ack, hold until the peripheral drops its request.
      ack_nx[i]   = (~dma_ack[i] & hs_ok[i]) | (dma_ack[i] & dma_reqs[i]);
      tc_nx[i]    = (~dma_tc[i] & hs_ok[i] & tsz_eq0) | (dma_tc[i] & dma_reqs[i]);
    end
  end

  always_ff @(posedge HCLK or negedge HRSTn)
  begin
    if (!HRSTn)
    begin
      dma_ack <= '0;
      dma_tc  <= '0;
    end
    else
    begin
      dma_ack <= ack_nx;
      dma_tc  <= tc_nx;
    end
  end

endmodule

`default_nettype wire

// File: src/dma_pri_sel.sv
`default_nettype none
`timescale 1ns/1ps

module dma_pri_sel (
  input  logic                                            HCLK,
  input  logic                                            HRSTn,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                  vld_req,
  input  dma_types_pkg::pri_e [dma_cfg_pkg::NUM_CH-1:0]   ch_pri,
  input  logic                                            de_stup,
  input  logic                                            de_st_idle,
  input  logic                                            de_abt_on_idle,
  output logic [dma_cfg_pkg::CH_W-1:0]                    arb_ch_sel,
  output logic                                            arb_req
);

  import dma_cfg_pkg::*;
  import dma_types_pkg::*;

  logic [NUM_CH-1:0]     lvl_req [PRI_LEVELS];
  logic [CH_W-1:0]       lvl_gnt [PRI_LEVELS];
  logic [PRI_LEVELS-1:0] lvl_any;
  pri_e                  pri_nx;
  pri_e                  pri_sel;
  arb_state_e            arb_st;
  logic                  vld_any;
  logic                  vld_any_d1;
  logic                  de_stup_d1;
  logic                  next_ch;

  always_comb
  begin
    for (int l = 0; l < PRI_LEVELS; l++)
    begin
      for (int i = 0; i < NUM_CH; i++)
      begin
        lvl_req[l][i] = vld_req[i] & (ch_pri[i] == pri_e'(l));
      end
      lvl_any[l] = |lvl_req[l];
    end
  end

  // the last hit is the highest level; level 0 when nothing requests.
  always_comb
  begin
    pri_nx = PRI_0;
    for (int l = 0; l < PRI_LEVELS; l++)
    begin
      if (lvl_any[l])
      begin
        pri_nx = pri_e'(l);
      end
    end
  end

  genvar g;
  generate
    for (g = 0; g < PRI_LEVELS; g++)
    begin : g_lvl
      dma_rr_arb u_rr_arb (
        .HCLK     (HCLK),
        .HRSTn    (HRSTn),
        .vld_req  (lvl_req[g]),
        .next_ch  (next_ch),
        .gnt_chno (lvl_gnt[g])
      );
    end
  endgenerate

  assign vld_any = |vld_req;
  assign next_ch = (vld_any & ~vld_any_d1 & de_st_idle) | de_stup_d1 | de_abt_on_idle;

  always_ff @(posedge HCLK or negedge HRSTn)
  begin
    if (!HRSTn)
    begin
      pri_sel    <= PRI_0;
      vld_any_d1 <= 1'b0;
      de_stup_d1 <= 1'b0;
    end
    else
    begin
      vld_any_d1 <= vld_any;
      de_stup_d1 <= de_stup;
      if (next_ch)
      begin
        pri_sel <= pri_nx;
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRSTn)
  begin
    if (!HRSTn)
    begin
      arb_st <= ARB_IDLE;
    end
    else if (de_abt_on_idle || (arb_st == ARB_PEND && de_stup))
    begin
      arb_st <= ARB_IDLE;
    end
    else if (arb_st == ARB_IDLE && !de_stup_d1 && vld_any)
    begin
      arb_st <= ARB_PEND;  // wait one cycle after setup so the grant can move.
    end
  end

  assign arb_req    = (arb_st == ARB_PEND);
  assign arb_ch_sel = lvl_gnt[pri_sel];

endmodule

`default_nettype wire

// File: src/dma_req_qualify.sv
`default_nettype none
`timescale 1ns/1ps

module dma_req_qualify (
  input  logic                                                  glb_en,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                        ch_en,
  input  dma_types_pkg::xfer_mode_e [dma_cfg_pkg::NUM_CH-1:0]   ch_mode,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                        ch_abt,
  input  logic                                                  de_err_notify,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                        dma_reqs,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                        dma_ack,
  input  logic [dma_cfg_pkg::NUM_CH-1:0]                        ch_taken,
  output logic [dma_cfg_pkg::NUM_CH-1:0]                        vld_req,
  output logic [dma_cfg_pkg::NUM_CH-1:0]                        abnormal
);

  import dma_cfg_pkg::*;
  import dma_types_pkg::*;

  logic [NUM_CH-1:0] hw_vld;
  logic [NUM_CH-1:0] sw_mode;

  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      abnormal[i] = de_err_notify | ch_abt[i];
      sw_mode[i]  = (ch_mode[i] == MODE_SW);
      // a request already served or already acked must not win again.
      hw_vld[i]   = dma_reqs[i] & ~dma_ack[i] & ~ch_taken[i];
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_CH; i++)
    begin
      vld_req[i] = glb_en & ch_en[i] & ~abnormal[i] & (sw_mode[i] | hw_vld[i]);
    end
  end

endmodule

`default_nettype wire

// File: src/dma_req_sync.sv
`default_nettype none
`timescale 1ns/1ps

module dma_req_sync (
  input  logic                           HCLK,
  input  logic                           HRSTn,
  input  logic [dma_cfg_pkg::NUM_CH-1:0] dma_req,
  input  logic [dma_cfg_pkg::NUM_CH-1:0] sync,
  output logic [dma_cfg_pkg::NUM_CH-1:0] dma_reqs
);

  import dma_cfg_pkg::*;

  logic [NUM_CH-1:0] req_d1;
  logic [NUM_CH-1:0] req_d2;

  // both ranks follow dma_req through reset as well.
  always_ff @(posedge HCLK)
  begin
    req_d1 <= dma_req;
    req_d2 <= req_d1 & sync;  // second rank only toggles for sync channels.
  end

  // asynchronous requesters see one more cycle of latency.
  assign dma_reqs = (sync & req_d2) | (~sync & req_d1);

endmodule

`default_nettype wire

// File: src/dma_rr_arb.sv
`default_nettype none
`timescale 1ns/1ps

module dma_rr_arb (
  input  logic                           HCLK,
  input  logic                           HRSTn,
  input  logic [dma_cfg_pkg::NUM_CH-1:0] vld_req,
  input  logic                           next_ch,
  output logic [dma_cfg_pkg::CH_W-1:0]   gnt_chno
);

  import dma_cfg_pkg::*;

  logic [CH_W-1:0] gnt_nx;
  logic [CH_W-1:0] idx;
  logic            found;

  // search starts one past the last grant, so the last grant is checked last.
  always_comb
  begin
    gnt_nx = gnt_chno;
    found  = 1'b0;
    idx    = gnt_chno;
    for (int k = 1; k <= NUM_CH; k++)
    begin
      idx = CH_W'((gnt_chno + k) % NUM_CH);
      if (!found && vld_req[idx])
      begin
        gnt_nx = idx;
        found  = 1'b1;
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRSTn)
  begin
    if (!HRSTn)
    begin
      gnt_chno <= CH_W'(NUM_CH - 1);  // channel 0 wins first.
    end
    else if (next_ch)
    begin
      gnt_chno <= gnt_nx;
    end
  end

endmodule

`default_nettype wire

// File: src/dma_types_pkg.sv
`default_nettype none

package dma_types_pkg;

  import dma_cfg_pkg::*;

  typedef enum logic {
    MODE_SW = 1'b0,  // software started, no peripheral handshake.
    MODE_HW = 1'b1   // follows dma_req and gets dma_ack/dma_tc.
  } xfer_mode_e;

  typedef enum logic [PRI_W-1:0] {
    PRI_0,  // lowest.
    PRI_1,
    PRI_2,
    PRI_3   // highest.
  } pri_e;

  typedef enum logic {
    ARB_IDLE,
    ARB_PEND  // arb_req is up and waits for de_stup.
  } arb_state_e;

endpackage

`default_nettype wire

// File: tests/dma_chsel_golden.txt
# name kind glb_en ch_en mode sync abt dma_req err tsz_eq0 pri0..pri3 grant0..grant5 ack tc
# kind 0 grants, 1 no request, 2 handshake (err rides on de_ack), 3 abort on idle; masks are bit 3..0
fixed_pri      0 1 1111 0000 0000 0000 0000 0 0 0 1 3 2 2 2 2 2 2 2 0000 0000
fixed_pri_low  0 1 0011 0000 0000 0000 0000 0 0 2 1 3 3 0 0 0 0 0 0 0000 0000
rr_three       0 1 1101 0000 0000 0000 0000 0 0 2 0 2 2 0 2 3 0 2 3 0000 0000
rr_four        0 1 1111 0000 0000 0000 0000 0 0 1 1 1 1 0 1 2 3 0 1 0000 0000
rr_mixed       0 1 1111 0000 0000 0000 0000 0 0 1 1 0 0 0 1 0 1 0 1 0000 0000
abt_skip       0 1 1111 0000 0000 0010 0000 0 0 3 3 3 3 0 2 3 0 2 3 0000 0000
abt_hi_skip    0 1 1111 0000 0000 0100 0000 0 0 0 0 3 0 0 1 3 0 1 3 0000 0000
q_glb_off      1 0 1111 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0 0 0 0000 0000
q_ch_off       1 1 0000 0000 0000 0000 0000 0 0 0 0 0 0 0 0 0 0 0 0 0000 0000
q_all_abt      1 1 0101 0000 0000 0101 0000 0 0 0 0 0 0 0 0 0 0 0 0 0000 0000
q_err          1 1 1111 0000 0000 0000 0000 1 0 0 0 0 0 0 0 0 0 0 0 0000 0000
q_hw_noreq     1 1 1111 1111 0000 0000 0000 0 0 0 0 0 0 0 0 0 0 0 0 0000 0000
hs_nosync      2 1 0010 0010 0000 0000 0010 0 0 0 2 0 0 1 0 0 0 0 0 0010 0000
hs_sync        2 1 1000 1000 1000 0000 1000 0 0 0 0 0 3 3 0 0 0 0 0 1000 0000
hs_mixed       2 1 0011 0010 0000 0000 0010 0 0 0 3 0 0 1 0 0 0 0 0 0010 0000
tc_nosync      2 1 0100 0100 0000 0000 0100 0 1 0 0 1 0 2 0 0 0 0 0 0100 0100
tc_sync        2 1 0001 0001 0001 0000 0001 0 1 2 0 0 0 0 0 0 0 0 0 0001 0001
tc_err         2 1 0010 0010 0000 0000 0010 1 1 0 0 0 0 1 0 0 0 0 0 0000 0000
abort_idle     3 1 1011 0000 0000 0000 0000 0 0 1 1 0 1 1 3 0 1 3 0 0000 0000
abort_idle_two 3 1 0110 0000 0000 0000 0000 0 0 2 2 2 2 2 1 2 1 2 1 0000 0000

// File: tests/tb_dma_chsel.sv
`default_nettype none
`timescale 1ns/1ps

module tb_dma_chsel;

  import dma_cfg_pkg::*;
  import dma_types_pkg::*;

  localparam int MAX_TESTS = 32;
  localparam int NUM_GNT   = 6;
  localparam int ARB_WAIT  = 50;

  logic                    HCLK;
  logic                    HRSTn;
  logic [NUM_CH-1:0]       dma_req;
  logic [NUM_CH-1:0]       sync;
  logic                    glb_en;
  logic [NUM_CH-1:0]       ch_en;
  logic [NUM_CH-1:0]       ch_abt;
  xfer_mode_e [NUM_CH-1:0] ch_mode;
  pri_e [NUM_CH-1:0]       ch_pri;
  logic                    de_err_notify;
  logic                    de_ack;
  logic                    de_stup;
  logic                    de_st_idle;
  logic                    de_abt_on_idle;
  logic                    tsz_eq0;
  logic [NUM_CH-1:0]       dma_ack;
  logic [NUM_CH-1:0]       dma_tc;
  logic [CH_W-1:0]         arb_ch_sel;
  logic                    arb_req;

  string             t_name [MAX_TESTS];  // one entry per golden line.
  int                t_kind [MAX_TESTS];
  logic              t_glb  [MAX_TESTS];
  logic              t_err  [MAX_TESTS];
  logic              t_tsz  [MAX_TESTS];
  logic [NUM_CH-1:0] t_en   [MAX_TESTS];
  logic [NUM_CH-1:0] t_mode [MAX_TESTS];
  logic [NUM_CH-1:0] t_sync [MAX_TESTS];
  logic [NUM_CH-1:0] t_abt  [MAX_TESTS];
  logic [NUM_CH-1:0] t_req  [MAX_TESTS];
  logic [NUM_CH-1:0] t_ack  [MAX_TESTS];
  logic [NUM_CH-1:0] t_tc   [MAX_TESTS];
  int                t_pri  [MAX_TESTS][NUM_CH];
  int                t_gnt  [MAX_TESTS][NUM_GNT];

  int          n_tests;
  int          err_count;
  int          pass_tests;
  int          fail_tests;
  bit          loaded;
  logic [31:0] lfsr_state;

  dma_chsel dut0 (.*);

  always #2 HCLK = ~HCLK;

  // the feedback of x^32 + x^22 + x^2 + x + 1 enters at bit 0.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_idle_cycles(output int n);
    n = 0;
    for (int b = 0; b < 2; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      n = n * 2 + int'(lfsr_state[0]);
    end
  endtask

  task automatic check_value(input int t, input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("mismatch %s: %s expected %0h actual %0h", t_name[t], what, exp_v, act_v);
      err_count++;
    end
  endtask

  task automatic report_error(input int t, input string msg);
    $display("%s: %s", t_name[t], msg);
    err_count++;
  endtask

  task automatic load_golden();
    int    fd;
    int    r;
    string line;
    string nm;
    int    kd, gl, er, tz;
    int    en, md, sy, ab, rq, ak, tc;
    int    p0, p1, p2, p3;
    int    g0, g1, g2, g3, g4, g5;
    fd = $fopen("tests/dma_chsel_golden.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open tests/dma_chsel_golden.txt");
      err_count++;
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS)
    begin
      line = "";
      r = $fgets(line, fd);
      if (r == 0 || line.len() < 2 || line[0] == "#")
      begin
        continue;
      end
      r = $sscanf(line, "%s %d %d %b %b %b %b %b %d %d %d %d %d %d %d %d %d %d %d %d %b %b",
                  nm, kd, gl, en, md, sy, ab, rq, er, tz, p0, p1, p2, p3,
                  g0, g1, g2, g3, g4, g5, ak, tc);
      if (r != 22)
      begin
        $display("malformed golden line: %s", line);
        err_count++;
        continue;
      end
      t_name[n_tests] = nm;
      t_kind[n_tests] = kd;
      t_glb[n_tests]  = gl[0];
      t_err[n_tests]  = er[0];
      t_tsz[n_tests]  = tz[0];
      t_en[n_tests]   = en[NUM_CH-1:0];
      t_mode[n_tests] = md[NUM_CH-1:0];
      t_sync[n_tests] = sy[NUM_CH-1:0];
      t_abt[n_tests]  = ab[NUM_CH-1:0];
      t_req[n_tests]  = rq[NUM_CH-1:0];
      t_ack[n_tests]  = ak[NUM_CH-1:0];
      t_tc[n_tests]   = tc[NUM_CH-1:0];
      t_pri[n_tests]  = '{p0, p1, p2, p3};
      t_gnt[n_tests]  = '{g0, g1, g2, g3, g4, g5};
      n_tests++;
    end
    $fclose(fd);
  endtask

  task automatic apply_reset(input int t);
    @(negedge HCLK);
    HRSTn          = 1'b0;
    glb_en         = t_glb[t];
    ch_en          = t_en[t];
    ch_abt         = t_abt[t];
    sync           = t_sync[t];
    dma_req        = t_req[t];
    tsz_eq0        = t_tsz[t];
    de_err_notify  = (t_kind[t] == 2) ? 1'b0 : t_err[t];
    de_ack         = 1'b0;
    de_stup        = 1'b0;
    de_st_idle     = 1'b1;
    de_abt_on_idle = 1'b0;
    for (int i = 0; i < NUM_CH; i++)
    begin
      ch_mode[i] = xfer_mode_e'(t_mode[t][i]);
      ch_pri[i]  = pri_e'(t_pri[t][i]);
    end
    repeat (3) @(negedge HCLK);
    HRSTn = 1'b1;
  endtask

  task automatic wait_arb(output bit ok);
    int n;
    n = 0;
    while (arb_req !== 1'b1 && n < ARB_WAIT)
    begin
      @(negedge HCLK);
      n++;
    end
    ok = (arb_req === 1'b1);
  endtask

  // the engine idles a few cycles, then runs a one-cycle setup that takes the grant.
  task automatic engine_setup(input int t, output logic [CH_W-1:0] ch, output bit ok);
    int idle;
    wait_arb(ok);
    if (!ok)
    begin
      report_error(t, "arb_req did not rise within 50 cycles");
      return;
    end
    pick_idle_cycles(idle);
    repeat (idle) @(negedge HCLK);
    de_stup    = 1'b1;
    de_st_idle = 1'b0;
    ch         = arb_ch_sel;
    @(negedge HCLK);
    de_stup    = 1'b0;
    de_st_idle = 1'b1;
  endtask

  task automatic run_grants(input int t);
    logic [CH_W-1:0] ch;
    bit              ok;
    for (int k = 0; k < NUM_GNT; k++)
    begin
      engine_setup(t, ch, ok);
      if (!ok)
      begin
        return;
      end
      check_value(t, $sformatf("grant %0d", k), 32'(t_gnt[t][k]), 32'(ch));
    end
  endtask

  task automatic run_quiet(input int t);
    bit rose;
    rose = 1'b0;
    repeat (ARB_WAIT)
    begin
      @(negedge HCLK);
      if (arb_req !== 1'b0)
      begin
        rose = 1'b1;
      end
    end
    if (rose)
    begin
      report_error(t, "arb_req rose although no channel is qualified");
    end
  endtask

  task automatic run_handshake(input int t);
    logic [CH_W-1:0] ch;
    bit              ok;
    int              n;
    engine_setup(t, ch, ok);
    if (!ok)
    begin
      return;
    end
    check_value(t, "grant 0", 32'(t_gnt[t][0]), 32'(ch));
    de_ack        = 1'b1;
    de_st_idle    = 1'b0;
    de_err_notify = t_err[t];  // the engine flags its error with the data ack.
    @(negedge HCLK);
    de_ack        = 1'b0;
    de_st_idle    = 1'b1;
    de_err_notify = 1'b0;
    check_value(t, "dma_ack", 32'(t_ack[t]), 32'(dma_ack));
    check_value(t, "dma_tc", 32'(t_tc[t]), 32'(dma_tc));
    dma_req = '0;
    n = 0;
    while ((dma_ack !== '0 || dma_tc !== '0) && n < 4)
    begin
      @(negedge HCLK);
      n++;
    end
    if (dma_ack !== '0 || dma_tc !== '0)
    begin
      report_error(t, "dma_ack or dma_tc still high 4 cycles after dma_req was released");
    end
  endtask

  task automatic run_abort(input int t);
    bit ok;
    wait_arb(ok);
    if (!ok)
    begin
      report_error(t, "arb_req did not rise within 50 cycles");
      return;
    end
    de_abt_on_idle = 1'b1;
    @(negedge HCLK);
    de_abt_on_idle = 1'b0;
    if (arb_req !== 1'b0)
    begin
      report_error(t, "arb_req stayed high after de_abt_on_idle");
    end
    run_grants(t);
  endtask

  initial
  begin
    wait (loaded && n_tests > 0);
    repeat (200 * n_tests) @(posedge HCLK);
    $display("watchdog expired after %0d cycles", 200 * n_tests);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    int errs_before;
    HCLK           = 1'b0;
    HRSTn          = 1'b0;
    dma_req        = '0;
    sync           = '0;
    glb_en         = 1'b0;
    ch_en          = '0;
    ch_abt         = '0;
    for (int i = 0; i < NUM_CH; i++)
    begin
      ch_mode[i] = MODE_SW;
      ch_pri[i]  = PRI_0;
    end
    de_err_notify  = 1'b0;
    de_ack         = 1'b0;
    de_stup        = 1'b0;
    de_st_idle     = 1'b1;
    de_abt_on_idle = 1'b0;
    tsz_eq0        = 1'b0;
    lfsr_state     = 32'h6a651173;
    load_golden();
    loaded = 1'b1;
    for (int t = 0; t < n_tests; t++)
    begin
      errs_before = err_count;
      apply_reset(t);
      case (t_kind[t])
        0: run_grants(t);
        1: run_quiet(t);
        2: run_handshake(t);
        3: run_abort(t);
        default: report_error(t, "unknown test kind in the golden file");
      endcase
      if (err_count == errs_before)
      begin
        pass_tests++;
        $display("pass  %s", t_name[t]);
      end
      else
      begin
        fail_tests++;
        $display("FAIL  %s (%0d errors)", t_name[t], err_count - errs_before);
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors", n_tests, pass_tests,
             fail_tests, err_count);
    if (err_count == 0 && fail_tests == 0 && n_tests > 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
